// File: project.f
design/isa_pkg.sv
design/dbus_pkg.sv
design/exe_alu.sv
design/hilo_unit.sv
design/dbus_req.sv
design/exe_stage.sv
dv/dbus_responder.sv
dv/tb_exe_stage.sv

// File: run.sh
#!/bin/sh
# compile and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exe_stage \
    -f project.f --Mdir obj_dir -o sim_exe_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exe_stage > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

// File: dv/tb_exe_stage.sv
`timescale 1ns/1ps

module tb_exe_stage import isa_pkg::*, dbus_pkg::*; ();

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] pc;
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_e     mem_op;
        logic        ex;
        excode_e     excode;
        logic [31:0] badvaddr;
        logic        req;
        logic        wr;
        size_e       size;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } item_t;

    logic clk = 1'b0;
    logic reset;
    logic ds_valid, gr_we, ds_ex, ms_allowin, flush, data_addr_ok;
    alu_op_e alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic [15:0] imm;
    logic [31:0] rs_value, rt_value, pc, ds_badvaddr;
    logic [4:0] dest;
    md_op_e md_op;
    mem_op_e mem_op;
    excode_e ds_excode;
    logic es_allowin, es_to_ms_valid, es_gr_we, es_ex, data_req, data_wr;
    logic [31:0] es_result, es_pc, es_badvaddr, data_addr, data_wdata;
    logic [4:0] es_dest;
    mem_op_e es_mem_op;
    excode_e es_excode;
    size_e data_size;
    logic [3:0] data_wstrb;

    int seed = 80;
    int errors = 0;
    int timeouts = 0;
    int head = 0;
    int tail = 0;
    int exp_reqs = 0;
    int acc_count = 0;
    int dropped_reqs = 0;
    logic acc_seen;
    logic leave;
    logic [31:0] ref_hi = '0;
    logic [31:0] ref_lo = '0;
    item_t exp_q [0:1023];
    item_t cur;

    always #5 clk = ~clk;

    exe_stage dut0 (.*);

    dbus_responder u_resp (
        .clk          (clk),
        .reset        (reset),
        .data_req     (data_req),
        .data_addr_ok (data_addr_ok)
    );

    assign leave = es_to_ms_valid && ms_allowin;
    assign cur   = exp_q[head];

    always @(posedge clk) begin
        if (reset) begin
            acc_seen <= 1'b0;
        end else if (flush) begin
            // a flushed item is dropped without leaving
            if (head != tail) begin
                head <= head + 1;
                if (cur.req && !acc_seen) begin
                    dropped_reqs <= dropped_reqs + 1;
                end
            end
            acc_seen <= 1'b0;
        end else if (leave) begin
            head     <= head + 1;
            acc_seen <= 1'b0;
        end else if (data_req && data_addr_ok) begin
            acc_seen  <= 1'b1;
            acc_count <= acc_count + 1;
        end
    end

    // random back-pressure from the memory stage
    initial begin
        ms_allowin = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            ms_allowin = reset || (rand_below(4) != 0);
        end
    end

    a_leave_known: assert property (@(posedge clk) disable iff (reset) leave |-> head != tail)
        else begin
            errors++;
            $display("an item left the stage with no instruction outstanding at %0t", $time);
        end

    a_fields: assert property (@(posedge clk) disable iff (reset)
        leave |-> es_result == cur.result && es_pc == cur.pc && es_dest == cur.dest
            && es_gr_we == cur.gr_we && es_mem_op == cur.mem_op)
        else begin
            errors++;
            $display("mismatch %0t: pc %h result %h expected %h", $time,
                     $sampled(cur.pc), $sampled(es_result), $sampled(cur.result));
        end

    a_exception: assert property (@(posedge clk) disable iff (reset)
        leave |-> es_ex == cur.ex && es_excode == cur.excode && es_badvaddr == cur.badvaddr)
        else begin
            errors++;
            $display("mismatch %0t: pc %h exception %b code %0d badvaddr %h", $time,
                     $sampled(cur.pc), $sampled(es_ex), $sampled(es_excode),
                     $sampled(es_badvaddr));
        end

    a_request: assert property (@(posedge clk) disable iff (reset)
        data_req && data_addr_ok |-> !acc_seen && data_addr == cur.result
            && data_wr == cur.wr && data_size == cur.size && data_wstrb == cur.wstrb
            && (!cur.wr || data_wdata == cur.wdata))
        else begin
            errors++;
            $display("mismatch %0t: request addr %h strobe %b data %h for pc %h", $time,
                     $sampled(data_addr), $sampled(data_wstrb), $sampled(data_wdata),
                     $sampled(cur.pc));
        end

    a_no_request: assert property (@(posedge clk) disable iff (reset) data_req |-> cur.req)
        else begin
            errors++;
            $display("mismatch %0t: data_req raised for pc %h", $time, $sampled(cur.pc));
        end

    // memory items wait for the bus
    a_after_accept: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid |-> !cur.req || acc_seen)
        else begin
            errors++;
            $display("mismatch %0t: pc %h passed on before acceptance", $time, $sampled(cur.pc));
        end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                            logic [15:0] im);
        case (op)
            alu_add, alu_addu: return a + b;
            alu_sub, alu_subu: return a - b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_nor:  return ~(a | b);
            alu_sll:  return b << a[4:0];
            alu_srl:  return b >> a[4:0];
            alu_sra:  return 32'($signed(b) >>> a[4:0]);
            default:  return {im, 16'h0000};
        endcase
    endfunction

    // reference model, hi/lo follow program order
    task automatic build_item(output item_t e);
        logic [31:0] a, b, res;
        logic ov, aerr, st;
        longint sa, sb;
        longint unsigned ua, ub;
        a = (src1_sel == src1_sa) ? {27'd0, imm[10:6]} : (src1_sel == src1_pc) ? pc : rs_value;
        case (src2_sel)
            src2_simm:  b = {{16{imm[15]}}, imm};
            src2_uimm:  b = {16'h0000, imm};
            src2_eight: b = 32'd8;
            default:    b = rt_value;
        endcase
        res = alu_ref(alu_op, a, b, imm);
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'(a);
        ub = longint'(b);
        ov = (alu_op == alu_add && sa + sb != longint'($signed(res)))
            || (alu_op == alu_sub && sa - sb != longint'($signed(res)));
        aerr = ((mem_op == mem_lw || mem_op == mem_sw) && res[1:0] != 2'b00)
            || ((mem_op == mem_lh || mem_op == mem_lhu || mem_op == mem_sh) && res[0]);
        st = (mem_op == mem_sw || mem_op == mem_sh || mem_op == mem_sb);
        e.result = (md_op == md_mfhi) ? ref_hi : (md_op == md_mflo) ? ref_lo : res;
        e.pc = pc;
        e.dest = dest;
        e.gr_we = gr_we;
        e.mem_op = mem_op;
        e.ex = ds_ex || ov || aerr;
        e.excode = ds_ex ? ds_excode : ov ? ex_ov : aerr ? (st ? ex_ades : ex_adel) : ex_none;
        e.badvaddr = ds_ex ? ds_badvaddr : (!ov && aerr) ? res : 32'd0;
        e.req = (mem_op != mem_none) && !aerr && !ds_ex;
        e.wr = st;
        e.size = (mem_op inside {mem_lh, mem_lhu, mem_sh}) ? size_half
               : (mem_op inside {mem_lb, mem_lbu, mem_sb}) ? size_byte : size_word;
        e.wstrb = (mem_op == mem_sw) ? 4'b1111 : (mem_op == mem_sb) ? 4'b0001 << res[1:0]
                : (mem_op == mem_sh) ? (res[1] ? 4'b1100 : 4'b0011) : 4'b0000;
        e.wdata = (e.size == size_byte) ? {4{rt_value[7:0]}}
                : (e.size == size_half) ? {2{rt_value[15:0]}} : rt_value;
        if (!e.ex) begin
            case (md_op)
                md_mult:  {ref_hi, ref_lo} = 64'(sa * sb);
                md_multu: {ref_hi, ref_lo} = 64'(ua * ub);
                md_mthi:  ref_hi = rs_value;
                md_mtlo:  ref_lo = rs_value;
                default:  ;
            endcase
        end
    endtask

    task automatic send_instr();
        item_t e;
        int waited;
        build_item(e);
        ds_valid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!es_allowin && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (es_allowin) begin
            exp_q[tail] = e;
            tail++;
            if (e.req) exp_reqs++;
        end else begin
            timeouts++;
            $display("timeout: the stage never took the instruction at pc %h", pc);
        end
        @(posedge clk);
        #1;
        ds_valid = 1'b0;
        if (rand_below(4) == 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic flush_stage();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic base_fields();
        alu_op = alu_addu;
        src1_sel = src1_rs;
        src2_sel = src2_rt;
        md_op = md_none;
        mem_op = mem_none;
        ds_ex = 1'b0;
        pc = $random(seed) & 32'hfffffffc;
        dest = 5'(rand_below(32));
        gr_we = 1'b1;
        imm = 16'($random(seed));
        rs_value = $random(seed);
        rt_value = $random(seed);
    endtask

    task automatic alu_fields();
        base_fields();
        alu_op = alu_op_e'(4'(rand_below(14)));
        src1_sel = src1_sel_e'(2'(rand_below(3)));
        src2_sel = src2_sel_e'(2'(rand_below(4)));
        // push add/sub toward the overflow boundary
        if (rand_below(3) == 0) rs_value = 32'h7fffffff ^ (32'(rand_below(2)) << 31);
    endtask

    task automatic md_sequence();
        base_fields();
        if (rand_below(2) == 0) begin
            md_op = (rand_below(2) == 0) ? md_mult : md_multu;
        end else begin
            md_op = (rand_below(2) == 0) ? md_mthi : md_mtlo;
        end
        send_instr();
        md_op = md_mfhi;
        send_instr();
        md_op = md_mflo;
        send_instr();
    endtask

    initial begin
        reset = 1'b1;
        ds_valid = 1'b0;
        flush = 1'b0;
        ds_excode = ex_none;
        ds_badvaddr = '0;
        base_fields();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < 250; i++) begin
            case (rand_below(4))
                0: begin
                    alu_fields();
                    send_instr();
                end
                1: md_sequence();
                2: begin
                    base_fields();
                    mem_op = mem_op_e'(4'(1 + rand_below(8)));
                    src2_sel = src2_simm;
                    rs_value = $random(seed) & 32'hfffffffc;
                    imm = 16'(rand_below(8));
                    gr_we = !(mem_op inside {mem_sw, mem_sh, mem_sb});
                    send_instr();
                    // now and then drop the access while it waits
                    if (rand_below(3) == 0) begin
                        flush_stage();
                    end
                end
                default: begin
                    // decode exception on a memory or hi/lo instruction
                    alu_fields();
                    mem_op = mem_op_e'(4'(rand_below(9)));
                    md_op = (rand_below(2) == 0) ? md_mult : md_mthi;
                    ds_ex = 1'b1;
                    ds_excode = ex_adel;
                    ds_badvaddr = pc;
                    send_instr();
                    // hi/lo must read back unchanged
                    base_fields();
                    md_op = md_mfhi;
                    send_instr();
                    md_op = md_mflo;
                    send_instr();
                end
            endcase
        end
        for (int w = 0; w < 200 && head != tail; w++) @(negedge clk);
        if (head != tail) begin
            timeouts++;
            $display("timeout: %0d instructions never left the stage", tail - head);
        end
        assert (acc_count == exp_reqs - dropped_reqs) else begin
            errors++;
            $display("mismatch %0t: %0d requests accepted, %0d expected", $time,
                     acc_count, exp_reqs - dropped_reqs);
        end
        $display("items %0d, requests %0d, errors %0d, timeouts %0d",
                 tail, acc_count, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: dv/dbus_responder.sv
`timescale 1ns/1ps

module dbus_responder (
    input  logic clk,
    input  logic reset,
    input  logic data_req,
    output logic data_addr_ok
);

    int seed = 80;
    int delay;
    logic pending;

    // grant each request after 0 to 3 idle cycles
    initial begin
        data_addr_ok = 1'b0;
        pending = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            #1;
            data_addr_ok = 1'b0;
            if (reset) begin
                pending = 1'b0;
            end else if (data_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay = int'($unsigned($random(seed)) % 4);
                end
                if (delay == 0) begin
                    data_addr_ok = 1'b1;
                    pending = 1'b0;
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

// File: design/exe_stage.sv
`timescale 1ns/1ps

module exe_stage import isa_pkg::*, dbus_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ds_valid,
    input  alu_op_e               alu_op,
    input  src1_sel_e             src1_sel,
    input  src2_sel_e             src2_sel,
    input  logic [15:0]           imm,
    input  logic [xlen-1:0]       rs_value,
    input  logic [xlen-1:0]       rt_value,
    input  logic [xlen-1:0]       pc,
    input  logic [reg_addr_w-1:0] dest,
    input  logic                  gr_we,
    input  md_op_e                md_op,
    input  mem_op_e               mem_op,
    input  logic                  ds_ex,
    input  excode_e               ds_excode,
    input  logic [xlen-1:0]       ds_badvaddr,
    input  logic                  ms_allowin,
    input  logic                  flush,
    input  logic                  data_addr_ok,
    output logic                  es_allowin,
    output logic                  es_to_ms_valid,
    output logic [xlen-1:0]       es_result,
    output logic [reg_addr_w-1:0] es_dest,
    output logic                  es_gr_we,
    output mem_op_e               es_mem_op,
    output logic [xlen-1:0]       es_pc,
    output logic                  es_ex,
    output excode_e               es_excode,
    output logic [xlen-1:0]       es_badvaddr,
    output logic                  data_req,
    output logic                  data_wr,
    output size_e                 data_size,
    output logic [wstrb_w-1:0]    data_wstrb,
    output logic [xlen-1:0]       data_addr,
    output logic [xlen-1:0]       data_wdata
);

    logic            es_valid;
    alu_op_e         alu_op_r;
    src1_sel_e       src1_sel_r;
    src2_sel_e       src2_sel_r;
    logic [15:0]     imm_r;
    logic [xlen-1:0] rs_r;
    logic [xlen-1:0] rt_r;
    md_op_e          md_op_r;
    logic            ds_ex_r;
    excode_e         ds_excode_r;
    logic [xlen-1:0] ds_badvaddr_r;

    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic            overflow;
    logic [xlen-1:0] hilo_value;
    logic            go;
    logic            addr_error;
    logic            leave;

    assign es_allowin     = !es_valid || (go && ms_allowin);
    assign es_to_ms_valid = es_valid && go && !flush;
    assign leave          = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    // instruction payload
    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            alu_op_r      <= alu_op;
            src1_sel_r    <= src1_sel;
            src2_sel_r    <= src2_sel;
            imm_r         <= imm;
            rs_r          <= rs_value;
            rt_r          <= rt_value;
            es_pc         <= pc;
            es_dest       <= dest;
            es_gr_we      <= gr_we;
            md_op_r       <= md_op;
            es_mem_op     <= mem_op;
            ds_ex_r       <= ds_ex;
            ds_excode_r   <= ds_excode;
            ds_badvaddr_r <= ds_badvaddr;
        end
    end

    exe_alu u_alu (
        .alu_op     (alu_op_r),
        .src1_sel   (src1_sel_r),
        .src2_sel   (src2_sel_r),
        .imm        (imm_r),
        .rs_value   (rs_r),
        .rt_value   (rt_r),
        .pc         (es_pc),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .overflow   (overflow)
    );

    // hi/lo only change for an instruction that leaves cleanly
    hilo_unit u_hilo (
        .clk        (clk),
        .reset      (reset),
        .md_op      (md_op_r),
        .commit     (leave && !es_ex),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .rs_value   (rs_r),
        .hilo_value (hilo_value)
    );

    dbus_req u_dbus (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .flush        (flush),
        .mem_op       (es_mem_op),
        .blocked      (ds_ex_r),
        .alu_result   (alu_result),
        .rt_value     (rt_r),
        .leave        (leave),
        .data_addr_ok (data_addr_ok),
        .go           (go),
        .addr_error   (addr_error),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata)
    );

    assign es_result = (md_op_r == md_mfhi || md_op_r == md_mflo) ? hilo_value : alu_result;

    // decode exception first, then overflow, then alignment
    assign es_ex = es_valid && (ds_ex_r || overflow || addr_error);

    always_comb begin
        es_excode   = ex_none;
        es_badvaddr = '0;
        if (es_valid && ds_ex_r) begin
            es_excode   = ds_excode_r;
            es_badvaddr = ds_badvaddr_r;
        end else if (es_valid && overflow) begin
            es_excode = ex_ov;
        end else if (es_valid && addr_error) begin
            es_excode   = mem_is_store(es_mem_op) ? ex_ades : ex_adel;
            es_badvaddr = alu_result;
        end
    end

    // a clean memory item is only passed on the cycle after acceptance
    a_valid_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(es_to_ms_valid) |-> es_valid
            && (es_mem_op == mem_none || es_ex || $past(data_req && data_addr_ok)))
        else $error("es_to_ms_valid rose without a valid, accepted instruction");

    a_no_req_flush: assert property (@(posedge clk) disable iff (reset)
        flush |-> !data_req)
        else $error("data_req high during flush");

endmodule

// File: design/dbus_req.sv
`timescale 1ns/1ps

module dbus_req import isa_pkg::*, dbus_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_valid,
    input  logic               flush,
    input  mem_op_e            mem_op,
    input  logic               blocked,
    input  logic [xlen-1:0]    alu_result,
    input  logic [xlen-1:0]    rt_value,
    input  logic               leave,
    input  logic               data_addr_ok,
    output logic               go,
    output logic               addr_error,
    output logic               data_req,
    output logic               data_wr,
    output size_e              data_size,
    output logic [wstrb_w-1:0] data_wstrb,
    output logic [xlen-1:0]    data_addr,
    output logic [xlen-1:0]    data_wdata
);

    logic       is_mem;
    logic       is_store;
    logic       accepted;
    logic [1:0] pos;

    assign is_mem   = (mem_op != mem_none);
    assign is_store = mem_is_store(mem_op);
    assign pos      = alu_result[1:0];

    // alignment rules by access width
    always_comb begin
        case (mem_op)
            mem_lw, mem_sw:          addr_error = (pos != 2'b00);
            mem_lh, mem_lhu, mem_sh: addr_error = pos[0];
            default:                 addr_error = 1'b0;
        endcase
    end

    always_comb begin
        case (mem_op)
            mem_lh, mem_lhu, mem_sh: data_size = size_half;
            mem_lb, mem_lbu, mem_sb: data_size = size_byte;
            default:                 data_size = size_word;
        endcase
    end

    // byte lanes written, none for loads
    always_comb begin
        case (mem_op)
            mem_sb:  data_wstrb = 4'b0001 << pos;
            mem_sh:  data_wstrb = pos[1] ? 4'b1100 : 4'b0011;
            mem_sw:  data_wstrb = 4'b1111;
            default: data_wstrb = 4'b0000;
        endcase
    end

    always_comb begin
        case (data_size)
            size_byte: data_wdata = {4{rt_value[7:0]}};
            size_half: data_wdata = {2{rt_value[15:0]}};
            default:   data_wdata = rt_value;
        endcase
    end

    assign data_addr = alu_result;
    assign data_wr   = is_store;
    assign data_req  = es_valid && is_mem && !addr_error && !blocked && !accepted && !flush;

    // one request per instruction, held until it leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted <= 1'b0;
        end else if (leave || flush) begin
            accepted <= 1'b0;
        end else if (data_req && data_addr_ok) begin
            accepted <= 1'b1;
        end
    end

    assign go = !is_mem || addr_error || blocked || accepted;

    a_req_hold: assert property (@(posedge clk) disable iff (reset || flush)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr))
        else $error("data_req dropped or address moved before addr_ok");

endmodule

// File: design/hilo_unit.sv
`timescale 1ns/1ps

module hilo_unit import isa_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  md_op_e          md_op,
    input  logic            commit,
    input  logic [xlen-1:0] alu_src1,
    input  logic [xlen-1:0] alu_src2,
    input  logic [xlen-1:0] rs_value,
    output logic [xlen-1:0] hilo_value
);

    logic [xlen-1:0]   hi;
    logic [xlen-1:0]   lo;
    logic [2*xlen-1:0] prod_s;
    logic [2*xlen-1:0] prod_u;

    // operands extended to full width so the low 64 bits are exact
    assign prod_s = $signed({{xlen{alu_src1[xlen-1]}}, alu_src1})
                  * $signed({{xlen{alu_src2[xlen-1]}}, alu_src2});
    assign prod_u = {{xlen{1'b0}}, alu_src1} * {{xlen{1'b0}}, alu_src2};

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (md_op)
                md_mult: begin
                    hi <= prod_s[2*xlen-1:xlen];
                    lo <= prod_s[xlen-1:0];
                end
                md_multu: begin
                    hi <= prod_u[2*xlen-1:xlen];
                    lo <= prod_u[xlen-1:0];
                end
                md_mthi: hi <= rs_value;
                md_mtlo: lo <= rs_value;
                default: ;
            endcase
        end
    end

    assign hilo_value = (md_op == md_mfhi) ? hi : lo;

    // hi/lo only move on a committed instruction
    a_hilo_hold: assert property (@(posedge clk) disable iff (reset)
        !commit |=> $stable(hi) && $stable(lo))
        else $error("hi/lo written without commit");

endmodule

// File: design/exe_alu.sv
`timescale 1ns/1ps

module exe_alu import isa_pkg::*; (
    input  alu_op_e         alu_op,
    input  src1_sel_e       src1_sel,
    input  src2_sel_e       src2_sel,
    input  logic [15:0]     imm,
    input  logic [xlen-1:0] rs_value,
    input  logic [xlen-1:0] rt_value,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] alu_src1,
    output logic [xlen-1:0] alu_src2,
    output logic [xlen-1:0] alu_result,
    output logic            overflow
);

    logic [xlen-1:0] add_res;
    logic [xlen-1:0] sub_res;
    logic [4:0]      shamt;

    // source 1: shift amount comes from imm[10:6]
    always_comb begin
        case (src1_sel)
            src1_sa: alu_src1 = {{(xlen-5){1'b0}}, imm[10:6]};
            src1_pc: alu_src1 = pc;
            default: alu_src1 = rs_value;
        endcase
    end

    always_comb begin
        case (src2_sel)
            src2_simm:  alu_src2 = {{(xlen-16){imm[15]}}, imm};
            src2_uimm:  alu_src2 = {{(xlen-16){1'b0}}, imm};
            src2_eight: alu_src2 = 32'd8;
            default:    alu_src2 = rt_value;
        endcase
    end

    assign add_res = alu_src1 + alu_src2;
    assign sub_res = alu_src1 - alu_src2;
    assign shamt   = alu_src1[4:0];

    always_comb begin
        case (alu_op)
            alu_add, alu_addu: alu_result = add_res;
            alu_sub, alu_subu: alu_result = sub_res;
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, alu_src1 < alu_src2};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_sll:  alu_result = alu_src2 << shamt;
            alu_srl:  alu_result = alu_src2 >> shamt;
            alu_sra:  alu_result = $signed(alu_src2) >>> shamt;
            alu_lui:  alu_result = {imm, 16'd0};
            default:  alu_result = add_res;
        endcase
    end

    // signed overflow, trapping forms only
    always_comb begin
        case (alu_op)
            alu_add: overflow = (alu_src1[xlen-1] == alu_src2[xlen-1])
                                && (add_res[xlen-1] != alu_src1[xlen-1]);
            alu_sub: overflow = (alu_src1[xlen-1] != alu_src2[xlen-1])
                                && (sub_res[xlen-1] != alu_src1[xlen-1]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

// File: design/dbus_pkg.sv
package dbus_pkg;

    // strobe width, one bit per byte lane
    localparam int wstrb_w = 4;

    // encoding of data_size on the bus
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {src1_rs, src1_sa, src1_pc} src1_sel_e;

    typedef enum logic [1:0] {src2_rt, src2_simm, src2_uimm, src2_eight} src2_sel_e;

    typedef enum logic [2:0] {
        md_none, md_mult, md_multu, md_mfhi, md_mflo, md_mthi, md_mtlo
    } md_op_e;

    typedef enum logic [3:0] {
        mem_none, mem_lw, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_sw, mem_sh, mem_sb
    } mem_op_e;

    typedef enum logic [4:0] {
        ex_none = 5'd0,
        ex_adel = 5'd4,
        ex_ades = 5'd5,
        ex_ov   = 5'd12
    } excode_e;

    function automatic logic mem_is_load(mem_op_e op);
        return op inside {mem_lw, mem_lb, mem_lbu, mem_lh, mem_lhu};
    endfunction

    function automatic logic mem_is_store(mem_op_e op);
        return op inside {mem_sw, mem_sh, mem_sb};
    endfunction

endpackage
